// ==== hw/rsa_macros.svh ====
`ifndef RSA_MACROS_SVH
`define RSA_MACROS_SVH

// operand and residue width in bits
`define RSA_W 256

// iteration counters run 0..256, so one bit wider than log2(RSA_W)
`define RSA_CNT_W 9

`endif

// ==== hw/rsa_pkg.sv ====
`default_nettype none
`include "rsa_macros.svh"

package rsa_pkg;

	// one operand or residue mod N
	typedef logic [`RSA_W-1:0] rsa_word_t;

	// exponentiation controller
	typedef enum logic [1:0] {
		CORE_IDLE,
		CORE_PRESCALE,  // y -> y*R mod N
		CORE_MULTIPLY,  // both Montgomery products in flight
		CORE_ADVANCE    // launch the next pair
	} core_state_e;

	// shared by the pre-scaler and the Montgomery multiplier
	typedef enum logic [1:0] {
		ITER_IDLE,
		ITER_LOOP,
		ITER_FIX
	} iter_state_e;

endpackage

`default_nettype wire

// ==== hw/rsa_modprod.sv ====
`default_nettype none
`include "rsa_macros.svh"

// y * 2^RSA_W mod N by repeated doubling
module rsa_modprod (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_start,
	input  wire rsa_pkg::rsa_word_t i_n,
	input  wire rsa_pkg::rsa_word_t i_y,
	output rsa_pkg::rsa_word_t      o_result,
	output logic                    o_done
);
	import rsa_pkg::*;

	iter_state_e           state;
	logic [`RSA_CNT_W-1:0] count;
	logic                  launch;
	rsa_word_t             n_r;
	logic [`RSA_W:0]       acc;      // below 2N, needs the extra bit
	logic [`RSA_W:0]       acc_sub;
	rsa_word_t             acc_red;  // acc mod N

	assign launch = (state == ITER_IDLE) && i_start;

	// borrow out of acc - N says acc was already below N
	assign acc_sub = acc - {1'b0, n_r};
	assign acc_red = acc_sub[`RSA_W] ? acc[`RSA_W-1:0] : acc_sub[`RSA_W-1:0];

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state    <= ITER_IDLE;
			count    <= '0;
			o_done   <= 1'b0;
			o_result <= '0;
		end else begin
			o_done <= 1'b0;
			case (state)
				ITER_IDLE: begin
					if (i_start) begin
						state <= ITER_LOOP;
						count <= '0;
					end
				end
				ITER_LOOP: begin
					count <= count + 1'b1;
					if (count == `RSA_W - 1) begin
						state <= ITER_FIX;
					end
				end
				ITER_FIX: begin
					o_result <= acc_red; // last reduction of the doubled value
					o_done   <= 1'b1;
					state    <= ITER_IDLE;
				end
				default: state <= ITER_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (launch) begin
			n_r <= i_n;
			acc <= {1'b0, i_y}; // y < N assumed
		end else if (state == ITER_LOOP) begin
			acc <= {acc_red, 1'b0};
		end
	end

	// core samples the pre-scaled word exactly once
	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |=> !o_done);

endmodule

`default_nettype wire

// ==== hw/rsa_mont.sv ====
`default_nettype none
`include "rsa_macros.svh"

// radix-2 Montgomery product a*b*2^-RSA_W mod N
module rsa_mont (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_start,
	input  wire rsa_pkg::rsa_word_t i_n,
	input  wire rsa_pkg::rsa_word_t i_a,
	input  wire rsa_pkg::rsa_word_t i_b,
	output rsa_pkg::rsa_word_t      o_result,
	output logic                    o_done
);
	import rsa_pkg::*;

	iter_state_e           state;
	logic [`RSA_CNT_W-1:0] count;
	logic                  launch;
	rsa_word_t             n_r;
	rsa_word_t             b_r;
	rsa_word_t             a_sr;     // a, consumed from the LSB
	logic [`RSA_W:0]       sum;      // partial sum, stays below 2N
	logic [`RSA_W+1:0]     add_b;
	logic [`RSA_W+1:0]     add_n;
	logic [`RSA_W:0]       fix_sub;

	assign launch = (state == ITER_IDLE) && i_start;

	assign add_b = {1'b0, sum} + (a_sr[0] ? {2'b00, b_r} : '0);
	// adding N when odd makes the halving exact
	assign add_n = add_b + (add_b[0] ? {2'b00, n_r} : '0);

	assign fix_sub = sum - {1'b0, n_r};

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state    <= ITER_IDLE;
			count    <= '0;
			o_done   <= 1'b0;
			o_result <= '0;
		end else begin
			o_done <= 1'b0;
			case (state)
				ITER_IDLE: begin
					if (i_start) begin
						state <= ITER_LOOP;
						count <= '0;
					end
				end
				ITER_LOOP: begin
					count <= count + 1'b1;
					if (count == `RSA_W - 1) begin
						state <= ITER_FIX;
					end
				end
				ITER_FIX: begin
					// final conditional subtract, borrow means sum < N
					o_result <= fix_sub[`RSA_W] ? sum[`RSA_W-1:0] : fix_sub[`RSA_W-1:0];
					o_done   <= 1'b1;
					state    <= ITER_IDLE;
				end
				default: state <= ITER_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (launch) begin
			n_r  <= i_n;
			b_r  <= i_b;
			a_sr <= i_a;
			sum  <= '0;
		end else if (state == ITER_LOOP) begin
			a_sr <= a_sr >> 1;
			sum  <= add_n[`RSA_W+1:1]; // divide by two
		end
	end

	// the reduction only works for an odd modulus
	assert property (@(posedge i_clk) disable iff (!i_rst)
		launch |-> i_n[0]);

	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_done |=> !o_done);

endmodule

`default_nettype wire

// ==== hw/rsa_core.sv ====
`default_nettype none
`include "rsa_macros.svh"

// right-to-left binary exponentiation y^d mod N
// t runs in the Montgomery domain, m stays in the normal domain
module rsa_core (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_start,
	input  wire rsa_pkg::rsa_word_t i_a,       // cipher word y
	input  wire rsa_pkg::rsa_word_t i_d,       // private exponent
	input  wire rsa_pkg::rsa_word_t i_n,       // modulus
	output rsa_pkg::rsa_word_t      o_a_pow_d,
	output logic                    o_finished
);
	import rsa_pkg::*;

	core_state_e           state;
	rsa_word_t             a_r;
	rsa_word_t             d_r;
	rsa_word_t             n_r;
	rsa_word_t             m;
	rsa_word_t             t;
	logic [`RSA_CNT_W-1:0] idx;       // current key bit
	logic                  mod_start;
	logic                  mont_start;
	logic                  mod_done;
	logic                  mul_done;
	logic                  sq_done;
	rsa_word_t             pre_res;
	rsa_word_t             mul_res;
	rsa_word_t             sq_res;
	logic                  key_bit;
	rsa_word_t             m_upd;

	// advance lasts one cycle, so this is a single pulse
	assign mont_start = (state == CORE_ADVANCE);

	assign key_bit = d_r[idx[`RSA_CNT_W-2:0]];
	assign m_upd   = key_bit ? mul_res : m;

	rsa_modprod rsa_modprod_inst (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mod_start),
		.i_n      (n_r),
		.i_y      (a_r),
		.o_result (pre_res),
		.o_done   (mod_done)
	);

	// m * t * R^-1, m stays plain because t carries the R
	rsa_mont rsa_mont_mul (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mont_start),
		.i_n      (n_r),
		.i_a      (t),
		.i_b      (m),
		.o_result (mul_res),
		.o_done   (mul_done)
	);

	rsa_mont rsa_mont_sq (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mont_start),
		.i_n      (n_r),
		.i_a      (t),
		.i_b      (t),
		.o_result (sq_res),
		.o_done   (sq_done)
	);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state      <= CORE_IDLE;
			mod_start  <= 1'b0;
			o_finished <= 1'b0;
			idx        <= '0;
			m          <= rsa_word_t'(1);
			t          <= '0;
			o_a_pow_d  <= '0;
		end else begin
			mod_start  <= 1'b0;
			o_finished <= 1'b0;
			case (state)
				CORE_IDLE: begin
					if (i_start) begin
						mod_start <= 1'b1;
						m         <= rsa_word_t'(1);
						idx       <= '0;
						state     <= CORE_PRESCALE;
					end
				end
				CORE_PRESCALE: begin
					if (mod_done) begin
						t     <= pre_res; // y*R mod N
						state <= CORE_ADVANCE;
					end
				end
				CORE_ADVANCE: begin
					state <= CORE_MULTIPLY;
				end
				CORE_MULTIPLY: begin
					if (mul_done && sq_done) begin
						m   <= m_upd;
						t   <= sq_res;
						idx <= idx + 1'b1;
						if (idx == `RSA_W - 1) begin
							o_a_pow_d  <= m_upd;
							o_finished <= 1'b1;
							state      <= CORE_IDLE;
						end else begin
							state <= CORE_ADVANCE;
						end
					end
				end
				default: state <= CORE_IDLE;
			endcase
		end
	end

	// operands held for the whole run
	always_ff @(posedge i_clk) begin
		if (state == CORE_IDLE && i_start) begin
			a_r <= i_a;
			d_r <= i_d;
			n_r <= i_n;
		end
	end

	// one launch feeds both multipliers, so they must finish together
	assert property (@(posedge i_clk) disable iff (!i_rst)
		mul_done == sq_done);

endmodule

`default_nettype wire

// ==== hw/rsa256_top.sv ====
`default_nettype none

module rsa256_top (
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_start,
	input  wire rsa_pkg::rsa_word_t i_a,
	input  wire rsa_pkg::rsa_word_t i_d,
	input  wire rsa_pkg::rsa_word_t i_n,
	output rsa_pkg::rsa_word_t      o_a_pow_d,
	output logic                    o_finished
);

	// pin boundary, all timing lives in the core
	rsa_core rsa_core_inst (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_a        (i_a),
		.i_d        (i_d),
		.i_n        (i_n),
		.o_a_pow_d  (o_a_pow_d),
		.o_finished (o_finished)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_rsa256_ref.svh ====
`ifndef TB_RSA256_REF_SVH
`define TB_RSA256_REF_SVH

// a*b mod n by add-and-double, both operands below n
function automatic rsa_word_t mod_mul(
	input rsa_word_t a,
	input rsa_word_t b,
	input rsa_word_t n
);
	logic [`RSA_W:0] acc;  // up to 2n-1 before each reduction
	logic [`RSA_W:0] n_x;
	int              i;
	acc = '0;
	n_x = {1'b0, n};
	for (i = `RSA_W - 1; i >= 0; i--) begin
		acc = acc << 1;
		if (acc >= n_x) begin
			acc = acc - n_x;
		end
		if (b[i]) begin
			acc = acc + {1'b0, a};
			if (acc >= n_x) begin
				acc = acc - n_x;
			end
		end
	end
	return acc[`RSA_W-1:0];
endfunction

// y^d mod n, key scanned from the top bit down
function automatic rsa_word_t mod_exp(
	input rsa_word_t y,
	input rsa_word_t d,
	input rsa_word_t n
);
	rsa_word_t res;
	int        i;
	res = rsa_word_t'(1); // n > 1, so 1 is already reduced
	for (i = `RSA_W - 1; i >= 0; i--) begin
		res = mod_mul(res, res, n);
		if (d[i]) begin
			res = mod_mul(res, y, n);
		end
	end
	return res;
endfunction

`endif

// ==== testbench/tb_rsa256.sv ====
`default_nettype none
`include "rsa_macros.svh"

module tb_rsa256;
	import rsa_pkg::*;

	`include "tb_rsa256_ref.svh"

	localparam int num_tests       = 14;    // checked runs, the aborted one included
	localparam int cycles_per_test = 70000; // one run takes about 66.6k cycles
	localparam int clk_period      = 100;

	logic      clk = 1'b0;
	logic      rst;
	logic      start;
	rsa_word_t a;
	rsa_word_t d;
	rsa_word_t n;
	rsa_word_t a_pow_d;
	logic      finished;

	string     name_q[$];   // runs still waiting for o_finished
	rsa_word_t expect_q[$];
	int        pass_count = 0;
	int        fail_count = 0;

	rsa256_top rsa256_top_inst (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_a        (a),
		.i_d        (d),
		.i_n        (n),
		.o_a_pow_d  (a_pow_d),
		.o_finished (finished)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_result(input string name, input rsa_word_t expected,
			input rsa_word_t actual);
		if (actual === expected) begin
			pass_count++;
			$display("pass %s", name);
		end else begin
			fail_count++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic rsa_word_t random_word();
		rsa_word_t w;
		int        i;
		for (i = 0; i < 8; i++) begin
			w[i*32 +: 32] = $urandom();
		end
		return w;
	endfunction

	function automatic rsa_word_t random_odd_modulus();
		rsa_word_t w;
		w = random_word();
		w[`RSA_W-1] = 1'b1; // keeps any word below 2n
		w[0]        = 1'b1;
		return w;
	endfunction

	function automatic rsa_word_t random_below(input rsa_word_t nn);
		rsa_word_t w;
		w = random_word();
		if (w >= nn) begin
			w = w - nn;
		end
		return w;
	endfunction

	// one start pulse with its operands
	task automatic launch(input rsa_word_t y, input rsa_word_t dd, input rsa_word_t nn);
		@(posedge clk);
		start <= 1'b1;
		a     <= y;
		d     <= dd;
		n     <= nn;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_finished();
		@(negedge clk);
		while (!finished) begin
			@(negedge clk);
		end
	endtask

	task automatic run_case(input string name, input rsa_word_t y, input rsa_word_t dd,
			input rsa_word_t nn, input rsa_word_t expected);
		name_q.push_back(name);
		expect_q.push_back(expected);
		launch(y, dd, nn);
		wait_finished();
	endtask

	// compare every finished run mid-cycle
	always @(negedge clk) begin
		if (finished) begin
			if (expect_q.size() == 0) begin
				fail_count++;
				$display("error: o_finished pulsed with no run in progress");
			end else begin
				check_result(name_q.pop_front(), expect_q.pop_front(), a_pow_d);
			end
		end
	end

	initial begin
		rsa_word_t   y;
		rsa_word_t   dd;
		rsa_word_t   nn;
		int          pulses;
		int          k;
		void'($urandom(32'h1af));
		rst   = 1'b0;
		start = 1'b0;
		a     = '0;
		d     = '0;
		n     = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;

		run_case("d_one_small", rsa_word_t'(855), rsa_word_t'(1), rsa_word_t'(3233),
			rsa_word_t'(855));
		nn = random_odd_modulus();
		y  = random_below(nn);
		run_case("d_one_random", y, rsa_word_t'(1), nn, y); // y < n comes back as is
		run_case("d_zero", y, '0, nn, rsa_word_t'(1));

		// textbook key, p = 61 and q = 53
		run_case("small_855", rsa_word_t'(855), rsa_word_t'(2753), rsa_word_t'(3233),
			mod_exp(rsa_word_t'(855), rsa_word_t'(2753), rsa_word_t'(3233)));
		run_case("small_2790", rsa_word_t'(2790), rsa_word_t'(2753), rsa_word_t'(3233),
			rsa_word_t'(65));

		for (k = 0; k < 6; k++) begin
			nn = random_odd_modulus();
			y  = random_below(nn);
			dd = random_word();
			run_case($sformatf("random_%0d", k), y, dd, nn, mod_exp(y, dd, nn));
		end

		// starts while busy, once in pre-scale and once in the key loop
		nn = random_odd_modulus();
		y  = random_below(nn);
		dd = random_word();
		name_q.push_back("busy_start");
		expect_q.push_back(mod_exp(y, dd, nn));
		launch(y, dd, nn);
		repeat (100) @(posedge clk);
		launch(~y, dd ^ rsa_word_t'(1), nn ^ rsa_word_t'(2));
		repeat (30000) @(posedge clk);
		launch(y >> 1, ~dd, nn);
		wait_finished();

		// reset late in the key loop, a few hundred cycles before the run would end
		nn = random_odd_modulus();
		y  = random_below(nn);
		dd = random_word();
		launch(y, dd, nn);
		repeat (66400) @(posedge clk);
		rst    <= 1'b0;
		pulses = 0;
		for (k = 0; k < 10; k++) begin
			@(negedge clk);
			if (finished) pulses++;
			@(posedge clk);
		end
		rst <= 1'b1;
		for (k = 0; k < 1000; k++) begin
			@(negedge clk);
			if (finished) pulses++;
		end
		check_result("reset_mid_run", '0, rsa_word_t'(pulses));

		// new operands, so a run that outlived the reset gives a different word
		nn = random_odd_modulus();
		y  = random_below(nn);
		dd = random_word();
		run_case("reset_fresh_run", y, dd, nn, mod_exp(y, dd, nn));

		@(posedge clk);
		if (expect_q.size() != 0) begin
			fail_count++;
			$display("error: %0d runs never raised o_finished", expect_q.size());
		end
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(num_tests * cycles_per_test * clk_period);
		$display("error: the engine never finished, core state %0d",
			rsa256_top_inst.rsa_core_inst.state);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
+incdir+testbench
hw/rsa_pkg.sv
hw/rsa_modprod.sv
hw/rsa_mont.sv
hw/rsa_core.sv
hw/rsa256_top.sv
testbench/tb_rsa256.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the RSA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_rsa256 \
	-o tb_rsa256 > build.log 2>&1 &&
	./obj_dir/tb_rsa256 > sim.log 2>&1 ||
	{ cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
